//--- source/zap_cfg.svh
// ZAP subsystem configuration.
// Reset vector, immediate widths and register count.

`ifndef ZAP_CFG_SVH
`define ZAP_CFG_SVH

//////////////////////////////

`define ZAP_RESET_VECTOR        32'h0   // First fetch address.

`define ZAP_NUM_REGS            8       // General registers.

// Sign-extended fields.
`define ZAP_IMM_W               16      // ALU immediate, branch offset.
`define ZAP_OFF_W               12      // Load/store offset.

//////////////////////////////

`endif

//--- source/zap_pkg.sv
// ZAP shared types.
// Opcodes and the two views of one instruction word.

`include "zap_cfg.svh"

package zap_pkg;

        //////////////////////////////

        // Opcode field. Unlisted codes run as NOP.
        typedef enum logic [3:0] {
                op_nop  = 4'd0,
                op_addi = 4'd1,
                op_add  = 4'd2,
                op_xor  = 4'd3,
                op_b    = 4'd4,
                op_ldr  = 4'd5,
                op_str  = 4'd6,
                op_strb = 4'd7
        } zap_op_e;

        //////////////////////////////

        // ALU view. ADDI, ADD, XOR and B.
        typedef struct packed {
                logic [3:0]             op;     // Bits 31:28.
                logic [2:0]             rd;     // Destination.
                logic [2:0]             rn;     // First source.
                logic [2:0]             rm;     // Second source.
                logic [18-`ZAP_IMM_W:0] rsvd;   // Unused.
                logic [`ZAP_IMM_W-1:0]  imm;    // Immediate or branch offset.
        } zap_alu_fmt_t;

        // Memory view. LDR, STR and STRB.
        typedef struct packed {
                logic [3:0]             op;     // Bits 31:28.
                logic [2:0]             rd;     // Load target or store source.
                logic [2:0]             rn;     // Base.
                logic [9:0]             rsvd;   // Unused.
                logic [11:0]            off;    // Byte offset.
        } zap_mem_fmt_t;

        // One word, two decodes.
        typedef union packed {
                zap_alu_fmt_t           alu;
                zap_mem_fmt_t           mem;
        } zap_instr_u;

endpackage

//--- source/zap_mem_shim.sv
`timescale 1ns/10ps

// Memory shim in front of external RAM.
// Registers each CPU request onto the RAM port as a one cycle pulse
// and stalls the requester until the RAM answers or it is flushed.

module zap_mem_shim
(
        input  logic            i_clk,          // Clock.
        input  logic            i_arst_n,       // Async reset, active low.

        // CPU side.
        input  logic            i_cpu_ren,
        input  logic            i_cpu_wen,
        input  logic [31:0]     i_cpu_addr,
        input  logic [31:0]     i_cpu_data,
        input  logic [3:0]      i_cpu_ben,
        input  logic            i_cpu_flush,    // Drops a pending read.
        output logic [31:0]     o_cpu_data,
        output logic            o_cpu_stall,
        output logic            o_cpu_done,

        // RAM side. Flopped.
        output logic            o_ram_rd_en,
        output logic            o_ram_wr_en,
        output logic [31:0]     o_ram_addr,
        output logic [31:0]     o_ram_data,
        output logic [3:0]      o_ram_ben,
        input  logic [31:0]     i_ram_data,
        input  logic            i_ram_stall
);

localparam logic st_idle = 1'b0;
localparam logic st_pend = 1'b1;

logic state;            // Idle or pending.
logic pend_rd;          // Pending access is a read.
logic pulse;            // Enable on the RAM port now.
logic accept;           // Take a new request.
logic drop;             // Flush hits a pending read.

//////////////////////////////

assign pulse  = o_ram_rd_en | o_ram_wr_en;
assign accept = (state == st_idle) && (i_cpu_ren || i_cpu_wen) && !i_ram_stall;
assign drop   = (state == st_pend) && pend_rd && i_cpu_flush;

// RAM answers in the first unstalled cycle after the pulse.
assign o_cpu_done  = (state == st_pend) && !pulse && !i_ram_stall && !drop;
assign o_cpu_data  = i_ram_data;        // Valid with done.

// Idle shim passes the RAM stall so no request goes unaccepted.
assign o_cpu_stall = (state == st_pend) ? !(o_cpu_done || drop) : i_ram_stall;

//////////////////////////////

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                state       <= st_idle;
                pend_rd     <= 1'b0;
                o_ram_rd_en <= 1'b0;
                o_ram_wr_en <= 1'b0;
        end
        else
        begin
                o_ram_rd_en <= accept & i_cpu_ren;      // One cycle only.
                o_ram_wr_en <= accept & i_cpu_wen;

                if (accept)
                begin
                        state   <= st_pend;
                        pend_rd <= i_cpu_ren;
                end
                else if (o_cpu_done || drop)
                begin
                        state <= st_idle;               // Back for the next one.
                end
        end
end

// Request payload, held until the next accept.
always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                o_ram_addr <= i_cpu_addr;
                o_ram_data <= i_cpu_data;
                o_ram_ben  <= i_cpu_ben;
        end
end

// Requesters wait out the stall, so every request is taken.
a_req_taken: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_cpu_ren || i_cpu_wen) |-> accept);

endmodule

//--- source/zap_fetch.sv
`timescale 1ns/10ps
`include "zap_cfg.svh"

// Fetch stage.
// Keeps the PC, reads one instruction at a time through the code shim
// and holds it in the register that feeds decode.

module zap_fetch
(
        input  logic                    i_clk,
        input  logic                    i_arst_n,

        // Pipeline control from execute.
        input  logic                    i_clear,        // Flush and redirect.
        input  logic [31:0]             i_target,
        input  logic                    i_stall,

        // Code shim.
        output logic                    o_ren,
        output logic [31:0]             o_addr,
        input  logic [31:0]             i_data,
        input  logic                    i_done,
        input  logic                    i_busy,
        output logic                    o_flush,

        // To decode.
        output logic                    o_valid,
        output zap_pkg::zap_instr_u     o_instr,
        output logic [31:0]             o_pc
);

logic [31:0] pc;        // Next fetch address.
logic        waiting;   // Read in flight.

//////////////////////////////

// Issue when idle and the output slot is empty or draining now.
assign o_ren   = !waiting && !i_busy && !i_clear && (!o_valid || !i_stall);
assign o_addr  = pc;
assign o_flush = i_clear;       // Kill the read in flight.

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                pc      <= `ZAP_RESET_VECTOR;
                waiting <= 1'b0;
                o_valid <= 1'b0;
        end
        else if (i_clear)       // Clear wins over stall.
        begin
                pc      <= i_target;
                waiting <= 1'b0;
                o_valid <= 1'b0;
        end
        else
        begin
                if (o_ren)
                begin
                        pc      <= pc + 32'd4;
                        waiting <= 1'b1;
                end
                else if (i_done)
                begin
                        waiting <= 1'b0;
                end

                if (i_done)
                        o_valid <= 1'b1;        // Slot is empty here.
                else if (!i_stall)
                        o_valid <= 1'b0;        // Taken by decode.
        end
end

// Instruction and its address. PC already moved past it.
always_ff @(posedge i_clk)
begin
        if (i_done)
        begin
                o_instr <= i_data;
                o_pc    <= pc - 32'd4;
        end
end

endmodule

//--- source/zap_decode.sv
`timescale 1ns/10ps
`include "zap_cfg.svh"

// Decode stage.
// Picks the instruction view by opcode, sign-extends the immediate
// or offset, and registers the fields for execute.

module zap_decode
(
        input  logic                    i_clk,
        input  logic                    i_arst_n,
        input  logic                    i_clear,
        input  logic                    i_stall,

        // From fetch.
        input  logic                    i_valid,
        input  zap_pkg::zap_instr_u     i_instr,
        input  logic [31:0]             i_pc,

        // To execute.
        output logic                    o_valid,
        output zap_pkg::zap_op_e        o_op,
        output logic [2:0]              o_rd,
        output logic [2:0]              o_rn,
        output logic [2:0]              o_rm,
        output logic [31:0]             o_imm,
        output logic [31:0]             o_pc
);

import zap_pkg::*;

zap_op_e     op;
logic [2:0]  rd;
logic [2:0]  rn;
logic [2:0]  rm;
logic [31:0] imm;

//////////////////////////////

always_comb
begin
        // ALU view unless the opcode says memory.
        op  = op_nop;
        rd  = i_instr.alu.rd;
        rn  = i_instr.alu.rn;
        rm  = i_instr.alu.rm;
        imm = {{(32-`ZAP_IMM_W){i_instr.alu.imm[`ZAP_IMM_W-1]}}, i_instr.alu.imm};

        case (i_instr.alu.op)
        op_addi, op_add, op_xor, op_b:
        begin
                op = zap_op_e'(i_instr.alu.op);
        end
        op_ldr, op_str, op_strb:
        begin
                op  = zap_op_e'(i_instr.mem.op);
                rd  = i_instr.mem.rd;           // Data register.
                rn  = i_instr.mem.rn;           // Base.
                rm  = 3'd0;
                imm = {{(32-`ZAP_OFF_W){i_instr.mem.off[`ZAP_OFF_W-1]}},
                       i_instr.mem.off[`ZAP_OFF_W-1:0]};
        end
        default:
        begin
                op = op_nop;                    // Unknown code.
        end
        endcase
end

//////////////////////////////

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
                o_valid <= 1'b0;
        else if (i_clear)
                o_valid <= 1'b0;                // Younger than the branch.
        else if (!i_stall)
                o_valid <= i_valid;
end

// Fields for execute, frozen on stall.
always_ff @(posedge i_clk)
begin
        if (!i_stall)
        begin
                o_op  <= op;
                o_rd  <= rd;
                o_rn  <= rn;
                o_rm  <= rm;
                o_imm <= imm;
                o_pc  <= i_pc;
        end
end

endmodule

//--- source/zap_execute.sv
`timescale 1ns/10ps
`include "zap_cfg.svh"

// Execute stage.
// Register file, ALU, branch resolution and one load or store at a
// time. Drives the pipeline clear and stall.

module zap_execute
(
        input  logic                    i_clk,
        input  logic                    i_arst_n,

        // From decode.
        input  logic                    i_valid,
        input  zap_pkg::zap_op_e        i_op,
        input  logic [2:0]              i_rd,
        input  logic [2:0]              i_rn,
        input  logic [2:0]              i_rm,
        input  logic [31:0]             i_imm,
        input  logic [31:0]             i_pc,

        // Pipeline control.
        output logic                    o_clear,        // Taken branch.
        output logic [31:0]             o_target,
        output logic                    o_stall,        // Data access pending.

        // Data shim.
        output logic                    o_mem_ren,
        output logic                    o_mem_wen,
        output logic [31:0]             o_mem_addr,
        output logic [31:0]             o_mem_data,
        output logic [3:0]              o_mem_ben,
        input  logic [31:0]             i_mem_data,
        input  logic                    i_mem_done,
        input  logic                    i_mem_busy
);

import zap_pkg::*;

logic [31:0] rf [`ZAP_NUM_REGS];        // General registers.
logic [31:0] rn_val;
logic [31:0] rm_val;
logic [31:0] rd_val;                    // Store source.
logic [31:0] alu_res;
logic        alu_wr;                    // ALU writes rd.
logic        mem_op;                    // Load or store here.
logic        issued;                    // Shim has the access.
logic        mem_go;                    // Access may go out now.
logic [31:0] ea;                        // Byte address.

//////////////////////////////

assign rn_val = rf[i_rn];
assign rm_val = rf[i_rm];
assign rd_val = rf[i_rd];

always_comb
begin
        alu_wr  = i_valid;
        alu_res = rn_val + i_imm;
        case (i_op)
        op_addi : alu_res = rn_val + i_imm;
        op_add  : alu_res = rn_val + rm_val;
        op_xor  : alu_res = rn_val ^ rm_val;
        default : alu_wr  = 1'b0;       // No register result.
        endcase
end

// Branch is always taken. Offset counts words.
assign o_clear  = i_valid && (i_op == op_b);
assign o_target = i_pc + {i_imm[29:0], 2'b00};

//////////////////////////////

assign mem_op = i_valid && (i_op inside {op_ldr, op_str, op_strb});
assign mem_go = mem_op && !issued && !i_mem_busy;
assign ea     = rn_val + i_imm;

assign o_mem_ren  = mem_go && (i_op == op_ldr);
assign o_mem_wen  = mem_go && (i_op != op_ldr);
assign o_mem_addr = {ea[31:2], 2'b00};  // Word aligned.
assign o_mem_ben  = (i_op == op_strb) ? (4'b0001 << ea[1:0]) : 4'hf;
assign o_mem_data = (i_op == op_strb) ? {4{rd_val[7:0]}} : rd_val;

// Hold the front end until the shim answers.
assign o_stall = mem_op && !i_mem_done;

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                issued <= 1'b0;
                for (int i = 0; i < `ZAP_NUM_REGS; i++)
                        rf[i] <= 32'd0;
        end
        else
        begin
                if (i_mem_done)
                        issued <= 1'b0;
                else if (mem_go)
                        issued <= 1'b1;

                if (alu_wr)
                        rf[i_rd] <= alu_res;
                else if (mem_op && i_mem_done && (i_op == op_ldr))
                        rf[i_rd] <= i_mem_data;         // Load result.
        end
end

// A branch and the slot behind it never reach the data port.
a_clear_no_mem: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_clear |-> !(o_mem_ren || o_mem_wen) ##1 !(o_mem_ren || o_mem_wen));

endmodule

//--- source/zap_top.sv
`timescale 1ns/10ps

// ZAP subsystem top.
// Fetch, decode and execute with a registered shim on the code port
// and on the data port. Every RAM output comes from a flop.

module zap_top
(
        input  logic            i_clk,
        input  logic            i_arst_n,

        // Instruction RAM.
        output logic            o_iram_rd_en,
        output logic [31:0]     o_iram_addr,
        input  logic [31:0]     i_iram_data,
        input  logic            i_iram_stall,

        // Data RAM.
        output logic            o_dram_rd_en,
        output logic            o_dram_wr_en,
        output logic [31:0]     o_dram_addr,
        output logic [31:0]     o_dram_data,
        output logic [3:0]      o_dram_ben,
        input  logic [31:0]     i_dram_data,
        input  logic            i_dram_stall
);

import zap_pkg::*;

// Fetch to code shim.
logic        ic_ren;
logic [31:0] ic_addr;
logic [31:0] ic_data;
logic        ic_done;
logic        ic_busy;
logic        ic_flush;

// Execute to data shim.
logic        dc_ren;
logic        dc_wen;
logic [31:0] dc_addr;
logic [31:0] dc_wdata;
logic [3:0]  dc_ben;
logic [31:0] dc_rdata;
logic        dc_done;
logic        dc_busy;

// Stage registers.
zap_instr_u  f_instr;
logic        f_valid;
logic [31:0] f_pc;
logic        d_valid;
zap_op_e     d_op;
logic [2:0]  d_rd;
logic [2:0]  d_rn;
logic [2:0]  d_rm;
logic [31:0] d_imm;
logic [31:0] d_pc;

// Pipeline control.
logic        clear;
logic        stall;
logic [31:0] target;

//////////////////////////////

zap_fetch u_zap_fetch (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_clear (clear), .i_target (target), .i_stall (stall),
        .o_ren (ic_ren), .o_addr (ic_addr), .i_data (ic_data),
        .i_done (ic_done), .i_busy (ic_busy), .o_flush (ic_flush),
        .o_valid (f_valid), .o_instr (f_instr), .o_pc (f_pc)
);

zap_decode u_zap_decode (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_clear (clear), .i_stall (stall),
        .i_valid (f_valid), .i_instr (f_instr), .i_pc (f_pc),
        .o_valid (d_valid), .o_op (d_op), .o_rd (d_rd), .o_rn (d_rn),
        .o_rm (d_rm), .o_imm (d_imm), .o_pc (d_pc)
);

zap_execute u_zap_execute (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_valid (d_valid), .i_op (d_op), .i_rd (d_rd), .i_rn (d_rn),
        .i_rm (d_rm), .i_imm (d_imm), .i_pc (d_pc),
        .o_clear (clear), .o_target (target), .o_stall (stall),
        .o_mem_ren (dc_ren), .o_mem_wen (dc_wen), .o_mem_addr (dc_addr),
        .o_mem_data (dc_wdata), .o_mem_ben (dc_ben), .i_mem_data (dc_rdata),
        .i_mem_done (dc_done), .i_mem_busy (dc_busy)
);

//////////////////////////////

// Code side. Read only, flushed by a taken branch.
zap_mem_shim i_mem_shim_code (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_cpu_ren (ic_ren), .i_cpu_wen (1'b0), .i_cpu_addr (ic_addr),
        .i_cpu_data (32'd0), .i_cpu_ben (4'd0), .i_cpu_flush (ic_flush),
        .o_cpu_data (ic_data), .o_cpu_stall (ic_busy), .o_cpu_done (ic_done),
        .o_ram_rd_en (o_iram_rd_en), .o_ram_wr_en (), .o_ram_addr (o_iram_addr),
        .o_ram_data (), .o_ram_ben (),
        .i_ram_data (i_iram_data), .i_ram_stall (i_iram_stall)
);

// Data side. Never flushed.
zap_mem_shim i_mem_shim_data (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_cpu_ren (dc_ren), .i_cpu_wen (dc_wen), .i_cpu_addr (dc_addr),
        .i_cpu_data (dc_wdata), .i_cpu_ben (dc_ben), .i_cpu_flush (1'b0),
        .o_cpu_data (dc_rdata), .o_cpu_stall (dc_busy), .o_cpu_done (dc_done),
        .o_ram_rd_en (o_dram_rd_en), .o_ram_wr_en (o_dram_wr_en),
        .o_ram_addr (o_dram_addr), .o_ram_data (o_dram_data), .o_ram_ben (o_dram_ben),
        .i_ram_data (i_dram_data), .i_ram_stall (i_dram_stall)
);

endmodule

//--- verif/zap_tb_model.svh
// Testbench reference model.
// LCG, random program generator and instruction-set model.

localparam int PROG_LEN   = 48;         // Words. Last one is the end loop.
localparam int IMEM_WORDS = 64;
localparam int DMEM_WORDS = 256;
localparam int MAX_STALL  = 4;          // Longest stall run.

logic [31:0] lcg_state = 32'h7d67802b;
logic [31:0] prog [IMEM_WORDS];
logic [31:0] model_mem [DMEM_WORDS];
logic [31:0] exp_fetch [$];             // Executed instruction addresses.
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];
logic [3:0]  exp_st_ben [$];
logic [31:0] exp_ld_addr [$];

//////////////////////////////

function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

function automatic int unsigned rand_below(int unsigned n);
        return (lcg_next() >> 8) % n;   // Upper bits spread better.
endfunction

// Start value of data word idx.
function automatic logic [31:0] fill_word(int unsigned idx);
        return (idx * 32'h9e3779b1) ^ {idx[15:0], 16'h5aa5};
endfunction

// Byte-lane write into an old word.
function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] data,
                                            logic [3:0] ben);
        logic [31:0] res;
        int          b;
        res = old;
        for (b = 0; b < 4; b++)
                if (ben[b])
                        res[8*b +: 8] = data[8*b +: 8];
        return res;
endfunction

//////////////////////////////

// Random program. R7 is never written, so it stays a zero base.
task automatic build_program();
        int          i;
        int unsigned kind;
        int unsigned off;
        int unsigned boff;
        logic [2:0]  rd;
        logic [2:0]  rn;
        logic [2:0]  rm;
        logic [3:0]  nop_op;
        for (i = 0; i < IMEM_WORDS; i++)
                prog[i] = {4'hf, 28'(i * 28'h9e3779b)};        // Filler, runs as NOP.
        for (i = 0; i < PROG_LEN - 1; i++)
        begin
                kind   = rand_below(8);
                rd     = 3'(rand_below(7));
                rn     = 3'(rand_below(8));
                rm     = 3'(rand_below(8));
                off    = rand_below(1024);                      // Inside 256 words.
                boff   = 4 + rand_below(4);                     // Forward only.
                nop_op = (rand_below(2) == 0) ? 4'h0 : 4'(8 + rand_below(8));
                case (kind)
                1: prog[i] = {op_add, rd, rn, rm, 3'b000, 16'(lcg_next())};
                2: prog[i] = {op_xor, rd, rn, rm, 3'b000, 16'(lcg_next())};
                3:
                begin
                        if (i + boff <= PROG_LEN - 1)
                                prog[i] = {op_b, rd, rn, rm, 3'b000, 16'(boff)};
                        else
                                prog[i] = {op_addi, rd, rn, rm, 3'b000, 16'(lcg_next())};
                end
                4: prog[i] = {op_ldr, rd, 3'd7, 10'd0, 12'(off)};
                5: prog[i] = {op_str, rm, 3'd7, 10'd0, 12'(off)};
                6: prog[i] = {op_strb, rm, 3'd7, 10'd0, 12'(off)};
                7: prog[i] = {nop_op, 28'(lcg_next())};
                default: prog[i] = {op_addi, rd, rn, rm, 3'b000, 16'(lcg_next())};
                endcase
        end
        prog[PROG_LEN-1] = {op_b, 28'd0};                      // Branch to self.
endtask

// Instruction-set model over the program.
task automatic run_model();
        logic [31:0] regs [`ZAP_NUM_REGS];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] wa;
        logic [31:0] data;
        logic [3:0]  ben;
        logic        halted;
        int          i;
        for (i = 0; i < `ZAP_NUM_REGS; i++)
                regs[i] = 32'd0;
        for (i = 0; i < DMEM_WORDS; i++)
                model_mem[i] = fill_word(i);
        pc     = `ZAP_RESET_VECTOR;
        halted = 1'b0;
        while (!halted && exp_fetch.size() < 4 * PROG_LEN)
        begin
                w   = prog[pc[7:2]];
                imm = {{(32-`ZAP_IMM_W){w[`ZAP_IMM_W-1]}}, w[`ZAP_IMM_W-1:0]};
                ea  = regs[w[24:22]] + {{(32-`ZAP_OFF_W){w[`ZAP_OFF_W-1]}},
                                        w[`ZAP_OFF_W-1:0]};
                wa  = {ea[31:2], 2'b00};                        // Word aligned.
                exp_fetch.push_back(pc);
                pc  = pc + 32'd4;
                case (w[31:28])
                op_addi: regs[w[27:25]] = regs[w[24:22]] + imm;
                op_add:  regs[w[27:25]] = regs[w[24:22]] + regs[w[21:19]];
                op_xor:  regs[w[27:25]] = regs[w[24:22]] ^ regs[w[21:19]];
                op_b:
                begin
                        halted = (imm == 32'd0);                // Self loop ends it.
                        pc     = exp_fetch[$] + 32'd4 * imm;
                end
                op_ldr:
                begin
                        exp_ld_addr.push_back(wa);
                        regs[w[27:25]] = model_mem[wa[9:2]];
                end
                op_str, op_strb:
                begin
                        ben  = (w[31:28] == op_str) ? 4'hf : (4'b0001 << ea[1:0]);
                        data = (w[31:28] == op_str) ? regs[w[27:25]] : {4{regs[w[27:25]][7:0]}};
                        exp_st_addr.push_back(wa);
                        exp_st_data.push_back(data);
                        exp_st_ben.push_back(ben);
                        model_mem[wa[9:2]] = merge_lanes(model_mem[wa[9:2]], data, ben);
                end
                default: ;                                      // NOP and unused codes.
                endcase
        end
endtask

//--- verif/zap_tb.sv
`timescale 1ns/10ps
`include "zap_cfg.svh"

// Testbench for the ZAP subsystem.
// Random program against the instruction-set model, with code and
// data RAM models that insert random stall cycles.

module zap_tb;

import zap_pkg::*;

`include "zap_tb_model.svh"

localparam int TIMEOUT_CYCLES = 40 * PROG_LEN * MAX_STALL;

logic        i_clk;
logic        i_arst_n;
logic        o_iram_rd_en;
logic [31:0] o_iram_addr;
logic [31:0] i_iram_data;
logic        i_iram_stall;
logic        o_dram_rd_en;
logic        o_dram_wr_en;
logic [31:0] o_dram_addr;
logic [31:0] o_dram_data;
logic [3:0]  o_dram_ben;
logic [31:0] i_dram_data;
logic        i_dram_stall;

logic [31:0] dmem [DMEM_WORDS];         // Data RAM contents.
logic        ipend;                     // Code read not yet answered.
logic        ipulse_last;               // Code pulse in the last cycle.
logic        dpend;
logic        dpulse_last;
int          irun;                      // Stall run lengths.
int          drun;
int          fptr;                      // Next expected executed address.
int          wrong_cnt;                 // Wrong-path fetches since a branch.
int          st_cnt;
int          ld_cnt;
logic [31:0] last_faddr;
logic        first_fetch;
logic        prog_done;                 // End loop fetched again.

zap_top i_zap_top (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .o_iram_rd_en   (o_iram_rd_en),
        .o_iram_addr    (o_iram_addr),
        .i_iram_data    (i_iram_data),
        .i_iram_stall   (i_iram_stall),
        .o_dram_rd_en   (o_dram_rd_en),
        .o_dram_wr_en   (o_dram_wr_en),
        .o_dram_addr    (o_dram_addr),
        .o_dram_data    (o_dram_data),
        .o_dram_ben     (o_dram_ben),
        .i_dram_data    (i_dram_data),
        .i_dram_stall   (i_dram_stall)
);

initial
begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;     // 40 ns period.
end

// Watchdog.
initial
begin
        repeat (TIMEOUT_CYCLES + 5) @(posedge i_clk);
        $display("Error: watchdog expired, the program never reached its end loop.");
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout after %0d cycles.", TIMEOUT_CYCLES);
end

//////////////////////////////

task automatic value_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("[ERROR] %s got 32'h%h, expected 32'h%h", name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first mismatch.");
endtask

task automatic rule_violation(string what);
        $display("Error: %s.", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first violation.");
endtask

task automatic draw_stall(inout int run, output logic stall);
        stall = (rand_below(3) == 0) && (run < MAX_STALL);
        run   = stall ? run + 1 : 0;
endtask

// Code RAM for one cycle. Stall still holds the last cycle's value.
task automatic code_ram_cycle();
        logic [31:0] a;
        if (ipend && !ipulse_last && !i_iram_stall)
                ipend = 1'b0;                   // Read answered.
        ipulse_last = 1'b0;
        if (o_iram_rd_en)
        begin
                a = o_iram_addr;
                assert (!ipend && !i_iram_stall)
                else rule_violation("code read pulse while the RAM was busy or stalled");
                ipend       = 1'b1;
                ipulse_last = 1'b1;
                i_iram_data = prog[a[7:2]];     // Valid from the next cycle.
                if (first_fetch)
                begin
                        assert (a == `ZAP_RESET_VECTOR)
                        else value_mismatch("o_iram_addr", a, `ZAP_RESET_VECTOR);
                end
                first_fetch = 1'b0;
                if (fptr == exp_fetch.size())
                begin
                        if (a == exp_fetch[$])
                                prog_done = 1'b1;
                end
                else if (a == exp_fetch[fptr])
                begin
                        fptr++;
                        wrong_cnt = 0;
                end
                else
                begin
                        // Sequential fetch behind a taken branch, later flushed.
                        assert (fptr > 0 && exp_fetch[fptr] != exp_fetch[fptr-1] + 32'd4
                                && a == last_faddr + 32'd4 && wrong_cnt < 3)
                        else value_mismatch("o_iram_addr", a, exp_fetch[fptr]);
                        wrong_cnt++;
                end
                last_faddr = a;
        end
endtask

// Data RAM for one cycle.
task automatic data_ram_cycle();
        logic [31:0] a;
        if (dpend && !dpulse_last && !i_dram_stall)
                dpend = 1'b0;
        dpulse_last = 1'b0;
        if (o_dram_rd_en || o_dram_wr_en)
        begin
                a = o_dram_addr;
                assert (!(o_dram_rd_en && o_dram_wr_en))
                else rule_violation("data read and write pulse in the same cycle");
                assert (!dpend && !i_dram_stall)
                else rule_violation("data pulse while the RAM was busy or stalled");
                dpend       = 1'b1;
                dpulse_last = 1'b1;
                if (o_dram_wr_en)
                begin
                        assert (st_cnt < exp_st_addr.size())
                        else rule_violation("more stores than the model made");
                        assert (a == exp_st_addr[st_cnt])
                        else value_mismatch("o_dram_addr", a, exp_st_addr[st_cnt]);
                        assert (o_dram_data == exp_st_data[st_cnt])
                        else value_mismatch("o_dram_data", o_dram_data, exp_st_data[st_cnt]);
                        assert (o_dram_ben == exp_st_ben[st_cnt])
                        else value_mismatch("o_dram_ben", o_dram_ben, exp_st_ben[st_cnt]);
                        dmem[a[9:2]] = merge_lanes(dmem[a[9:2]], o_dram_data, o_dram_ben);
                        st_cnt++;
                end
                else
                begin
                        assert (ld_cnt < exp_ld_addr.size())
                        else rule_violation("more loads than the model made");
                        assert (a == exp_ld_addr[ld_cnt])
                        else value_mismatch("o_dram_addr", a, exp_ld_addr[ld_cnt]);
                        i_dram_data = dmem[a[9:2]];
                        ld_cnt++;
                end
        end
endtask

//////////////////////////////

initial
begin
        int   i;
        logic bad;
        i_arst_n     = 1'b0;
        i_iram_stall = 1'b0;
        i_dram_stall = 1'b0;
        i_iram_data  = 32'd0;
        i_dram_data  = 32'd0;
        ipend        = 1'b0;
        ipulse_last  = 1'b0;
        dpend        = 1'b0;
        dpulse_last  = 1'b0;
        irun         = 0;
        drun         = 0;
        fptr         = 0;
        wrong_cnt    = 0;
        st_cnt       = 0;
        ld_cnt       = 0;
        last_faddr   = 32'd0;
        first_fetch  = 1'b1;
        prog_done    = 1'b0;
        build_program();
        run_model();
        for (i = 0; i < DMEM_WORDS; i++)
                dmem[i] = fill_word(i);

        // Reset for 5 cycles, enables stay low.
        repeat (5)
        begin
                @(posedge i_clk);
                #2;
                assert (!o_iram_rd_en && !o_dram_rd_en && !o_dram_wr_en)
                else rule_violation("RAM enable high during reset");
        end
        i_arst_n = 1'b1;

        while (!prog_done)
        begin
                @(posedge i_clk);
                #2;                             // Outputs settled, drive now.
                code_ram_cycle();
                data_ram_cycle();
                draw_stall(irun, i_iram_stall);
                draw_stall(drun, i_dram_stall);
        end

        assert (st_cnt == exp_st_addr.size())
        else value_mismatch("o_dram_wr_en pulses", st_cnt, exp_st_addr.size());
        assert (ld_cnt == exp_ld_addr.size())
        else value_mismatch("o_dram_rd_en pulses", ld_cnt, exp_ld_addr.size());

        // Final data memory against the model.
        bad = 1'b0;
        for (i = 0; i < DMEM_WORDS && !bad; i++)
        begin
                assert (dmem[i] == model_mem[i])
                else
                begin
                        $display("[ERROR] dmem[%h] got 32'h%h, expected 32'h%h",
                                 i, dmem[i], model_mem[i]);
                        bad = 1'b1;
                end
        end
        if (!bad)
        begin
                $display("ALL TESTS PASSED");
                $finish;
        end
        else
        begin
                $display("SOME TESTS FAILED");
                $fatal(1, "Final data memory differs from the model.");
        end
end

endmodule

//--- vlog.f
+incdir+source
+incdir+verif
source/zap_pkg.sv
source/zap_mem_shim.sv
source/zap_fetch.sv
source/zap_decode.sv
source/zap_execute.sv
source/zap_top.sv
verif/zap_tb.sv
